// File: files.f
design/tlp_stream_pkg.sv
design/irq_cfg_pkg.sv
design/tlp_rx_pack.sv
design/irq_gen.sv
design/tlp_tx_split.sv
design/pcie_user_top.sv
bench/tb_pcie_user.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PCIe user-side testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f files.f --top-module tb_pcie_user -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vtb_pcie_user); then
    echo "$out"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: bench/tb_pcie_user.sv
// ------------------------------
// PCIe user-side testbench
// Random receive packets, transmit words and interrupt
// handshakes checked against local reference models
// ------------------------------
`timescale 1ns/100ps

module tb_pcie_user;
    import tlp_stream_pkg::*;
    import irq_cfg_pkg::*;

    localparam int IRQ_PER  = 40;
    localparam int NPKT     = 40;
    localparam int NW       = 40;
    localparam int AREA_RX  = 0;
    localparam int AREA_TX  = 1;
    localparam int AREA_IRQ = 2;

    logic                   clk_pcie = 1'b0;
    logic                   rst;
    logic [CORE_DATA_W-1:0] rx_data;
    logic [CORE_KEEP_W-1:0] rx_keep;
    logic                   rx_last;
    logic [RX_USER_W-1:0]   rx_user;
    logic                   rx_valid;
    logic                   rx_ready;
    logic [TLP_DATA_W-1:0]  rxs_data;
    logic [TLP_DW_N-1:0]    rxs_keepdw;
    logic                   rxs_last;
    logic [TLP_USER_W-1:0]  rxs_user;
    logic                   rxs_valid;
    logic [TLP_DATA_W-1:0]  txs_data;
    logic [TLP_DW_N-1:0]    txs_keepdw;
    logic                   txs_last;
    logic                   txs_valid;
    logic                   txs_ready;
    logic [CORE_DATA_W-1:0] tx_data;
    logic [CORE_KEEP_W-1:0] tx_keep;
    logic                   tx_last;
    logic                   tx_valid;
    logic                   tx_ready = 1'b1;
    logic [CMD_W-1:0]       cfg_command;
    logic                   msi_enable;
    logic                   int_rdy;
    logic                   int_valid;
    logic                   int_assert;

    int    seed = 32'hb95b;
    int    errs [3];
    int    cyc = 0;
    logic  bp_on = 1'b0;
    string tx_test = "tx split";

    // Receive model state and expected streams
    logic [TLP_DATA_W-1:0] m_word;
    int                    m_cnt;
    logic                  m_first;
    logic [140:0]          rx_exp_q [$];
    logic [73:0]           tx_exp_q [$];
    logic [TLP_DATA_W-1:0] tw_data [NW];
    logic [TLP_DW_N-1:0]   tw_keep [NW];
    logic                  tw_last [NW];

    pcie_user_top #(.IRQ_PERIOD(IRQ_PER)) dut (.*);

    always #2 clk_pcie = ~clk_pcie;

    always @(posedge clk_pcie) cyc <= cyc + 1;

    // Core back-pressure on the transmit side
    always @(posedge clk_pcie) begin
        logic rdy_next;
        rdy_next = bp_on ? (rand_below(2) == 1) : 1'b1;
        #1;
        tx_ready = rdy_next;
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand_word();
        rand_below = int'(r % n);
    endfunction

    task automatic report_mismatch(input int area, input string name,
                                   input logic [159:0] want, input logic [159:0] got);
        $display("[FAIL] %s expected %0h actual %0h at %0t", name, want, got, $time);
        errs[area]++;
    endtask

    task automatic report_problem(input int area, input string msg);
        $display("Error at %0t: %s", $time, msg);
        errs[area]++;
    endtask

    task automatic tick();
        @(posedge clk_pcie);
        #1;
    endtask

    task automatic apply_reset();
        tick();
        rst = 1'b1;
        repeat (5) tick();
        rst = 1'b0;
    endtask

    // ------------------------------
    // Receive packing
    // ------------------------------
    task automatic model_rx_beat(input logic [63:0] d, input logic two,
                                 input logic last, input logic [BAR_HIT_W-1:0] bar);
        logic [TLP_DW_N-1:0]   kd;
        logic [TLP_DATA_W-1:0] mask;
        m_word[32*m_cnt +: 32] = d[31:0];
        if (two) begin
            m_word[32*(m_cnt+1) +: 32] = d[63:32];
        end
        m_cnt = m_cnt + (two ? 2 : 1);
        // Word closes past two DWs or at packet end
        if (m_cnt > 2 || last) begin
            mask = '0;
            for (int i = 0; i < TLP_DW_N; i++) begin
                kd[i] = (i == 0) || (m_cnt > i);
                if (kd[i]) begin
                    mask[32*i +: 32] = '1;
                end
            end
            rx_exp_q.push_back({bar, last, m_first, kd, m_word & mask});
            m_first = last;
            m_cnt = 0;
        end
    endtask

    task automatic send_rx_packet();
        int          nbeats;
        logic        two;
        logic [31:0] u;
        nbeats = 1 + rand_below(6);
        for (int b = 0; b < nbeats; b++) begin
            if (rand_below(4) == 0) begin
                rx_valid = 1'b0;
                tick();
            end
            two = rand_below(2) == 1;
            u = rand_word();
            rx_data = {rand_word(), rand_word()};
            rx_keep = two ? KEEP_TWO_DW : KEEP_ONE_DW;
            rx_last = (b == nbeats - 1);
            rx_user = u[RX_USER_W-1:0];
            rx_valid = 1'b1;
            model_rx_beat(rx_data, two, rx_last, u[BAR_HIT_LSB +: BAR_HIT_W]);
            tick();
        end
        rx_valid = 1'b0;
    endtask

    always @(negedge clk_pcie) begin
        logic [140:0]          want;
        logic [TLP_DATA_W-1:0] mask;
        if (!rst && rxs_valid) begin
            if (rx_exp_q.size() == 0) begin
                report_problem(AREA_RX, "receive word with nothing expected");
            end else begin
                want = rx_exp_q.pop_front();
                mask = '0;
                for (int i = 0; i < TLP_DW_N; i++) begin
                    if (want[128+i]) begin
                        mask[32*i +: 32] = '1;
                    end
                end
                if ({rxs_user, rxs_keepdw, rxs_data & mask} !== want) begin
                    report_mismatch(AREA_RX, "rx pack", 160'(want),
                                    160'({rxs_user, rxs_keepdw, rxs_data & mask}));
                end
                // Packet end flag on its own port
                if (rxs_last !== want[133]) begin
                    report_mismatch(AREA_RX, "rx last", 160'(want[133]), 160'(rxs_last));
                end
            end
        end
        // Core must never be stalled
        if (!rst && rx_valid && rx_ready !== 1'b1) begin
            report_mismatch(AREA_RX, "rx ready", 160'(1), 160'(rx_ready));
        end
    end

    // ------------------------------
    // Transmit splitting
    // ------------------------------
    task automatic model_tx_word(input int i);
        logic lo_final;
        lo_final = !tw_keep[i][2];
        tx_exp_q.push_back({lo_final, tw_last[i] && lo_final,
                            tw_keep[i][1] ? KEEP_TWO_DW : KEEP_ONE_DW, tw_data[i][63:0]});
        if (tw_keep[i][2]) begin
            tx_exp_q.push_back({1'b1, tw_last[i],
                                tw_keep[i][3] ? KEEP_TWO_DW : KEEP_ONE_DW, tw_data[i][127:64]});
        end
    endtask

    task automatic send_tx_word(input int i);
        int t;
        txs_data   = tw_data[i];
        txs_keepdw = tw_keep[i];
        txs_last   = tw_last[i];
        txs_valid  = 1'b1;
        model_tx_word(i);
        t = 0;
        @(negedge clk_pcie);
        while (txs_ready !== 1'b1 && t < 100) begin
            @(negedge clk_pcie);
            t++;
        end
        if (txs_ready !== 1'b1) begin
            report_problem(AREA_TX, "transmit word never accepted");
        end
        tick();
        txs_valid = 1'b0;
    endtask

    task automatic run_tx_pass(input logic bp, input string name);
        tx_test = name;
        bp_on = bp;
        for (int i = 0; i < NW; i++) begin
            if (rand_below(4) == 0) begin
                tick();
            end
            send_tx_word(i);
        end
        if (tx_exp_q.size() != 0) begin
            report_problem(AREA_TX, "transmit beats missing at end of pass");
        end
    endtask

    // Accepted beats, txs_ready only with the final half
    always @(negedge clk_pcie) begin
        logic [73:0] want;
        if (!rst && tx_valid && tx_ready) begin
            if (tx_exp_q.size() == 0) begin
                report_problem(AREA_TX, "transmit beat with nothing expected");
            end else begin
                want = tx_exp_q.pop_front();
                if ({txs_ready, tx_last, tx_keep, tx_data} !== want) begin
                    report_mismatch(AREA_TX, tx_test, 160'(want),
                                    160'({txs_ready, tx_last, tx_keep, tx_data}));
                end
            end
        end else if (!rst && txs_ready) begin
            report_problem(AREA_TX, "txs_ready high with no beat accepted");
        end
    end

    // ------------------------------
    // Interrupt handshake
    // ------------------------------
    task automatic wait_int(output int at);
        int t;
        t = 0;
        @(negedge clk_pcie);
        while (int_valid !== 1'b1 && t < 3 * IRQ_PER) begin
            @(negedge clk_pcie);
            t++;
        end
        at = cyc;
        if (int_valid !== 1'b1) begin
            report_problem(AREA_IRQ, "int_valid never rose");
        end
    endtask

    // Called on the sample where int_valid is first seen high
    task automatic serve_int(input logic exp_assert, input string name);
        int d;
        if (int_assert !== exp_assert) begin
            report_mismatch(AREA_IRQ, {name, " level"}, 160'(exp_assert), 160'(int_assert));
        end
        d = rand_below(4);
        repeat (d) begin
            @(negedge clk_pcie);
            if ({int_valid, int_assert} !== {1'b1, exp_assert}) begin
                report_mismatch(AREA_IRQ, {name, " hold"}, 160'({1'b1, exp_assert}),
                                160'({int_valid, int_assert}));
            end
        end
        tick();
        int_rdy = 1'b1;
        tick();
        int_rdy = 1'b0;
        @(negedge clk_pcie);
        if (int_valid !== 1'b1) begin
            report_mismatch(AREA_IRQ, {name, " at rdy"}, 160'(1), 160'(int_valid));
        end
        // Falls one cycle after int_rdy is taken
        @(negedge clk_pcie);
        if (int_valid !== 1'b0) begin
            report_mismatch(AREA_IRQ, {name, " release"}, 160'(0), 160'(int_valid));
        end
    endtask

    task automatic check_silent(input string name);
        bit seen;
        seen = 1'b0;
        for (int t = 0; t < 3 * (IRQ_PER + 1); t++) begin
            @(negedge clk_pcie);
            if (int_valid !== 1'b0 && !seen) begin
                report_mismatch(AREA_IRQ, name, 160'(0), 160'(int_valid));
                seen = 1'b1;
            end
        end
    endtask

    initial begin
        int prev;
        int rise;
        int gap;
        int t;
        rst = 1'b1;
        rx_data = '0;
        rx_keep = '0;
        rx_last = 1'b0;
        rx_user = '0;
        rx_valid = 1'b0;
        txs_data = '0;
        txs_keepdw = '0;
        txs_last = 1'b0;
        txs_valid = 1'b0;
        cfg_command = '0;
        msi_enable = 1'b0;
        int_rdy = 1'b0;
        m_cnt = 0;
        m_first = 1'b1;
        apply_reset();

        for (int p = 0; p < NPKT; p++) begin
            send_rx_packet();
        end
        t = 0;
        while (rx_exp_q.size() != 0 && t < 20) begin
            tick();
            t++;
        end
        if (rx_exp_q.size() != 0) begin
            report_problem(AREA_RX, "receive words never emitted");
        end

        for (int i = 0; i < NW; i++) begin
            tw_data[i] = {rand_word(), rand_word(), rand_word(), rand_word()};
            tw_keep[i] = 4'((1 << (1 + rand_below(4))) - 1);
            tw_last[i] = rand_below(2) == 1;
        end
        run_tx_pass(1'b0, "tx split");
        run_tx_pass(1'b1, "tx backpressure");

        // MSI, timed from reset release
        tick();
        bp_on = 1'b0;
        cfg_command[CMD_BME_BIT] = 1'b1;
        msi_enable = 1'b1;
        apply_reset();
        prev = cyc;
        for (int k = 0; k < 5; k++) begin
            if (k == 3) begin
                tick();
                msi_enable = 1'b0;
            end
            wait_int(rise);
            // Request IRQ_PER+1 edges after release, valid one edge later
            gap = (k == 0) ? IRQ_PER + 2 : IRQ_PER + 1;
            if (rise - prev != gap) begin
                report_mismatch(AREA_IRQ, "int rise cycle", 160'(gap), 160'(rise - prev));
            end
            prev = rise;
            if (k < 3) begin
                serve_int(1'b0, "msi");
            end else begin
                serve_int(1'b1, "legacy assert");
                @(negedge clk_pcie);
                if ({int_valid, int_assert} !== 2'b10) begin
                    report_mismatch(AREA_IRQ, "legacy deassert rise", 160'(2'b10),
                                    160'({int_valid, int_assert}));
                end
                serve_int(1'b0, "legacy deassert");
            end
        end

        tick();
        cfg_command[CMD_INTX_DIS_BIT] = 1'b1;
        check_silent("legacy disabled");
        tick();
        cfg_command = '0;
        msi_enable = 1'b1;
        check_silent("bus master off");

        $display("Errors: receive %0d, transmit %0d, interrupt %0d",
                 errs[AREA_RX], errs[AREA_TX], errs[AREA_IRQ]);
        if (errs[AREA_RX] + errs[AREA_TX] + errs[AREA_IRQ] == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: design/pcie_user_top.sv
// ------------------------------
// PCIe user-side top
// Receive packer, interrupt generator and transmit splitter
// ------------------------------
`timescale 1ns/100ps

module pcie_user_top #(
    parameter int unsigned IRQ_PERIOD = irq_cfg_pkg::IRQ_PERIOD_DEFAULT
) (
    input  logic                                   clk_pcie,
    input  logic                                   rst,
    // Core receive stream
    input  logic [tlp_stream_pkg::CORE_DATA_W-1:0] rx_data,
    input  logic [tlp_stream_pkg::CORE_KEEP_W-1:0] rx_keep,
    input  logic                                   rx_last,
    input  logic [tlp_stream_pkg::RX_USER_W-1:0]   rx_user,
    input  logic                                   rx_valid,
    output logic                                   rx_ready,
    // Packed receive TLPs
    output logic [tlp_stream_pkg::TLP_DATA_W-1:0]  rxs_data,
    output logic [tlp_stream_pkg::TLP_DW_N-1:0]    rxs_keepdw,
    output logic                                   rxs_last,
    output logic [tlp_stream_pkg::TLP_USER_W-1:0]  rxs_user,
    output logic                                   rxs_valid,
    // Transmit TLPs
    input  logic [tlp_stream_pkg::TLP_DATA_W-1:0]  txs_data,
    input  logic [tlp_stream_pkg::TLP_DW_N-1:0]    txs_keepdw,
    input  logic                                   txs_last,
    input  logic                                   txs_valid,
    output logic                                   txs_ready,
    // Core transmit stream
    output logic [tlp_stream_pkg::CORE_DATA_W-1:0] tx_data,
    output logic [tlp_stream_pkg::CORE_KEEP_W-1:0] tx_keep,
    output logic                                   tx_last,
    output logic                                   tx_valid,
    input  logic                                   tx_ready,
    // Interrupt
    input  logic [irq_cfg_pkg::CMD_W-1:0]          cfg_command,
    input  logic                                   msi_enable,
    input  logic                                   int_rdy,
    output logic                                   int_valid,
    output logic                                   int_assert
);

    tlp_rx_pack u_rx_pack (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_keep    (rx_keep),
        .rx_last    (rx_last),
        .rx_user    (rx_user),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rxs_data   (rxs_data),
        .rxs_keepdw (rxs_keepdw),
        .rxs_last   (rxs_last),
        .rxs_user   (rxs_user),
        .rxs_valid  (rxs_valid)
    );

    irq_gen #(
        .IRQ_PERIOD (IRQ_PERIOD)
    ) u_irq_gen (
        .clk_pcie    (clk_pcie),
        .rst         (rst),
        .cfg_command (cfg_command),
        .msi_enable  (msi_enable),
        .int_rdy     (int_rdy),
        .int_valid   (int_valid),
        .int_assert  (int_assert)
    );

    tlp_tx_split u_tx_split (
        .clk_pcie   (clk_pcie),
        .rst        (rst),
        .txs_data   (txs_data),
        .txs_keepdw (txs_keepdw),
        .txs_last   (txs_last),
        .txs_valid  (txs_valid),
        .tx_ready   (tx_ready),
        .txs_ready  (txs_ready),
        .tx_data    (tx_data),
        .tx_keep    (tx_keep),
        .tx_last    (tx_last),
        .tx_valid   (tx_valid)
    );

endmodule

// File: design/tlp_tx_split.sv
// ------------------------------
// TLP transmit splitter
// Breaks 128-bit TLP words into one or two 64-bit core beats
// ------------------------------
`timescale 1ns/100ps

module tlp_tx_split (
    input  logic                                   clk_pcie,
    input  logic                                   rst,
    input  logic [tlp_stream_pkg::TLP_DATA_W-1:0]  txs_data,
    input  logic [tlp_stream_pkg::TLP_DW_N-1:0]    txs_keepdw,
    input  logic                                   txs_last,
    input  logic                                   txs_valid,
    input  logic                                   tx_ready,
    output logic                                   txs_ready,
    output logic [tlp_stream_pkg::CORE_DATA_W-1:0] tx_data,
    output logic [tlp_stream_pkg::CORE_KEEP_W-1:0] tx_keep,
    output logic                                   tx_last,
    output logic                                   tx_valid
);
    import tlp_stream_pkg::*;

    logic upper_sel;
    logic final_half;
    logic two_dw;

    // Upper half presented, or the word fits in the lower half
    assign final_half = upper_sel || !txs_keepdw[2];
    assign two_dw     = upper_sel ? txs_keepdw[3] : txs_keepdw[1];

    assign tx_valid  = txs_valid;
    assign tx_data   = upper_sel ? txs_data[TLP_DATA_W-1:CORE_DATA_W]
                                 : txs_data[CORE_DATA_W-1:0];
    assign tx_keep   = two_dw ? KEEP_TWO_DW : KEEP_ONE_DW;
    assign tx_last   = txs_last && final_half;
    assign txs_ready = txs_valid && tx_ready && final_half;

    // Half select moves only on beats the core takes
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            upper_sel <= 1'b0;
        end else if (txs_valid && tx_ready) begin
            upper_sel <= !final_half;
        end
    end

    a_keep_legal : assert property (@(posedge clk_pcie) disable iff (rst)
        tx_valid |-> (tx_keep == KEEP_ONE_DW) || (tx_keep == KEEP_TWO_DW));

endmodule

// File: design/irq_gen.sv
// ------------------------------
// Interrupt generator
// Free-running period timer whose requests go out as MSI
// or as a legacy assert/deassert pair
// ------------------------------
`timescale 1ns/100ps

module irq_gen #(
    parameter int unsigned IRQ_PERIOD = irq_cfg_pkg::IRQ_PERIOD_DEFAULT
) (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  logic [irq_cfg_pkg::CMD_W-1:0] cfg_command,
    input  logic                         msi_enable,
    input  logic                         int_rdy,
    output logic                         int_valid,
    output logic                         int_assert
);
    import irq_cfg_pkg::*;

    logic [31:0] period_cnt;
    logic        irq_req;
    logic        bme_on;
    logic        legacy_on;
    irq_state_t  state;

    assign bme_on    = cfg_command[CMD_BME_BIT];
    assign legacy_on = !cfg_command[CMD_INTX_DIS_BIT];

    // ------------------------------
    // Period timer
    // ------------------------------
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            period_cnt <= 32'd0;
            irq_req    <= 1'b0;
        end else if (period_cnt >= IRQ_PERIOD) begin
            period_cnt <= 32'd0;
            irq_req    <= 1'b1;
        end else begin
            period_cnt <= period_cnt + 32'd1;
            irq_req    <= 1'b0;
        end
    end

    // ------------------------------
    // Handshake FSM
    // ------------------------------
    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            int_valid  <= 1'b0;
            int_assert <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Requests outside idle are simply dropped
                    if (irq_req && bme_on) begin
                        if (msi_enable) begin
                            int_valid <= 1'b1;
                            state     <= ST_MSI_ASSERT;
                        end else if (legacy_on) begin
                            int_valid  <= 1'b1;
                            int_assert <= 1'b1;
                            state      <= ST_LEGACY_ASSERT_WAIT;
                        end
                    end
                end
                ST_MSI_ASSERT: begin
                    if (int_rdy) begin
                        state <= ST_MSI_RELEASE;
                    end
                end
                ST_MSI_RELEASE: begin
                    int_valid <= 1'b0;
                    state     <= ST_IDLE;
                end
                ST_LEGACY_ASSERT_WAIT: begin
                    if (int_rdy) begin
                        state <= ST_LEGACY_ASSERT_HOLD;
                    end
                end
                ST_LEGACY_ASSERT_HOLD: begin
                    int_valid <= 1'b0;
                    state     <= ST_LEGACY_WAIT_SERVICE;
                end
                ST_LEGACY_WAIT_SERVICE: begin
                    // Deassert message once the request pulse is gone
                    if (!irq_req) begin
                        int_valid  <= 1'b1;
                        int_assert <= 1'b0;
                        state      <= ST_LEGACY_DEASSERT_WAIT;
                    end
                end
                ST_LEGACY_DEASSERT_WAIT: begin
                    if (int_rdy) begin
                        state <= ST_LEGACY_DEASSERT_HOLD;
                    end
                end
                ST_LEGACY_DEASSERT_HOLD: begin
                    int_valid <= 1'b0;
                    state     <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Assert level must hold for the whole valid phase
    a_assert_stable : assert property (@(posedge clk_pcie) disable iff (rst)
        int_valid && $past(int_valid) |-> int_assert == $past(int_assert));

    // No interrupt leaves idle without bus mastering
    a_bme_gate : assert property (@(posedge clk_pcie) disable iff (rst)
        (state == ST_IDLE) && !bme_on |=> !int_valid);

endmodule

// File: design/tlp_rx_pack.sv
// ------------------------------
// TLP receive packer
// Collects 64-bit core receive beats into 128-bit TLP words
// with first, last and BAR-hit flags
// ------------------------------
`timescale 1ns/100ps

module tlp_rx_pack (
    input  logic                                 clk_pcie,
    input  logic                                 rst,
    input  logic [tlp_stream_pkg::CORE_DATA_W-1:0] rx_data,
    input  logic [tlp_stream_pkg::CORE_KEEP_W-1:0] rx_keep,
    input  logic                                 rx_last,
    input  logic [tlp_stream_pkg::RX_USER_W-1:0]   rx_user,
    input  logic                                 rx_valid,
    output logic                                 rx_ready,
    output logic [tlp_stream_pkg::TLP_DATA_W-1:0]  rxs_data,
    output logic [tlp_stream_pkg::TLP_DW_N-1:0]    rxs_keepdw,
    output logic                                 rxs_last,
    output logic [tlp_stream_pkg::TLP_USER_W-1:0]  rxs_user,
    output logic                                 rxs_valid
);
    import tlp_stream_pkg::*;

    logic [TLP_DATA_W-1:0] word_q;
    logic [2:0]            dw_cnt;
    logic                  first_q;
    logic                  last_q;
    logic [BAR_HIT_W-1:0]  bar_q;
    logic                  word_done;
    logic [2:0]            base;
    logic [2:0]            next_cnt;

    // Word is complete once more than two DWs are in, or the packet ended
    assign word_done = last_q || (dw_cnt > 3'd2);
    assign base      = word_done ? 3'd0 : dw_cnt;
    assign next_cnt  = base + 3'd1 + {2'b00, rx_keep[4]};

    // Core never stalls
    assign rx_ready = 1'b1;

    // Assembly register, beat lands at the current DW slot
    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            for (int i = 0; i < TLP_DW_N; i++) begin
                if (base == 3'(i)) begin
                    word_q[32*i +: 32] <= rx_data[31:0];
                end else if (base + 3'd1 == 3'(i)) begin
                    word_q[32*i +: 32] <= rx_data[63:32];
                end
            end
        end
    end

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            first_q <= 1'b1;
            last_q  <= 1'b0;
            dw_cnt  <= 3'd0;
            bar_q   <= '0;
        end else if (rx_valid) begin
            if (word_done) begin
                first_q <= last_q;
            end
            last_q <= rx_last;
            dw_cnt <= next_cnt;
            bar_q  <= rx_user[BAR_HIT_LSB +: BAR_HIT_W];
        end else if (word_done) begin
            first_q <= last_q;
            last_q  <= 1'b0;
            dw_cnt  <= 3'd0;
            bar_q   <= '0;
        end
    end

    // Slot n valid when more than n DWs collected
    always_comb begin
        for (int n = 0; n < TLP_DW_N; n++) begin
            rxs_keepdw[n] = (n == 0) || (dw_cnt > 3'(n));
        end
    end

    assign rxs_data  = word_q;
    assign rxs_last  = last_q;
    assign rxs_user  = {bar_q, last_q, first_q};
    assign rxs_valid = word_done;

    a_cnt_range : assert property (@(posedge clk_pcie) disable iff (rst)
        dw_cnt <= 3'd4);

endmodule

// File: design/irq_cfg_pkg.sv
// ------------------------------
// Interrupt configuration definitions
// Command word bits, interrupt FSM states and timer period
// ------------------------------

package irq_cfg_pkg;

    // PCI command register
    localparam int CMD_W            = 16;
    localparam int CMD_BME_BIT      = 2;
    localparam int CMD_INTX_DIS_BIT = 10;

    // 500 ms at 62.5 MHz
    localparam int unsigned IRQ_PERIOD_DEFAULT = 31_250_000;

    // ------------------------------
    // Interrupt handshake states
    // ------------------------------
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MSI_ASSERT,
        ST_MSI_RELEASE,
        ST_LEGACY_ASSERT_WAIT,
        ST_LEGACY_ASSERT_HOLD,
        ST_LEGACY_WAIT_SERVICE,
        ST_LEGACY_DEASSERT_WAIT,
        ST_LEGACY_DEASSERT_HOLD
    } irq_state_t;

endpackage

// File: design/tlp_stream_pkg.sv
// ------------------------------
// TLP stream definitions
// Widths and field positions of the 64-bit PCIe core stream
// and the 128-bit TLP word stream
// ------------------------------

package tlp_stream_pkg;

    // ------------------------------
    // Core side, 64-bit beats
    // ------------------------------
    localparam int CORE_DATA_W = 64;
    localparam int CORE_KEEP_W = 8;
    localparam int RX_USER_W   = 22;

    // BAR hit sits above the error bits in the core receive user field
    localparam int BAR_HIT_LSB = 2;
    localparam int BAR_HIT_W   = 7;

    // Byte keep for one or two valid doublewords
    localparam logic [CORE_KEEP_W-1:0] KEEP_ONE_DW = 8'h0f;
    localparam logic [CORE_KEEP_W-1:0] KEEP_TWO_DW = 8'hff;

    // ------------------------------
    // TLP side, 128-bit words
    // ------------------------------
    localparam int TLP_DATA_W = 128;
    localparam int TLP_DW_N   = 4;

    // User field: bit 0 first, bit 1 last, bits 8:2 BAR hit
    localparam int TLP_USER_W = 9;

endpackage
